// ==== common/aes_types_pkg.sv ====
// shared cipher types; every block and word keeps FIPS-197 byte order with byte 0 in the top bits.
`default_nettype none

package aes_types_pkg;

    // ********************************************************************
    // field constants
    // ********************************************************************
    localparam logic [7:0] XTIME_POLY = 8'h1b;   // x^8 reduction term of the AES field.
    localparam logic [7:0] RCON_INIT  = 8'h01;   // first round constant.

    // ********************************************************************
    // cipher data types
    // ********************************************************************
    typedef logic [7:0]   aes_byte_t;     // one state byte or one S-box entry.
    typedef logic [31:0]  aes_word_t;     // one state column or one key word.
    typedef logic [127:0] aes_block_t;    // full cipher state, byte 0 on top.
    typedef logic [255:0] aes_key_t;      // eight key words, word 0 on top.

    // host request, 384 bits.
    typedef struct packed {
        aes_key_t   key;          // cipher key.
        aes_block_t plaintext;    // block to encrypt.
    } enc_req_t;

    // multiply by x in GF(2^8), shared by MixColumns and the Rcon update.
    function automatic aes_byte_t xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? XTIME_POLY : 8'h00);
    endfunction

endpackage

`default_nettype wire

// ==== common/aes_ctrl_pkg.sv ====
// control types; the command is decoded from the FSM state, so it is low whenever the core is idle.
`default_nettype none

package aes_ctrl_pkg;

    localparam int unsigned NUM_ROUNDS = 14;   // AES-256 round count.
    localparam int unsigned ROUND_CNT_W = 4;   // wide enough for 1 to 14.

    typedef logic [ROUND_CNT_W-1:0] round_cnt_t;   // current round number.

    // sequencer states.
    typedef enum logic [2:0] {
        IDLE = 3'd0,   // waiting for req.
        LOAD = 3'd1,   // initial AddRoundKey and key window load.
        SUB  = 3'd2,   // S-box read cycle.
        MIX  = 3'd3,   // rest of the round, state and window update.
        DONE = 3'd4    // ciphertext held, ack toward the host.
    } aes_ctrl_state_e;

    // command to both datapaths, 4 bits.
    typedef struct packed {
        logic load;   // take plaintext and key.
        logic sub;    // S-box read cycle.
        logic step;   // update state and key window.
        logic last;   // final round, no MixColumns.
    } round_cmd_t;

endpackage

`default_nettype wire

// ==== hw/sbox/sbox_rom.sv ====
// forward S-box only; the table path is relative to the project root, so simulate from there.
`timescale 1ns/1ps
`default_nettype none

module sbox_rom
    import aes_types_pkg::*;
(
    input  logic      clk,    // read clock.
    input  aes_byte_t addr,   // byte to substitute.
    output aes_byte_t data    // substituted byte, one cycle later.
);

    aes_byte_t rom [0:255];   // Rijndael S-box.

    initial
    begin
        $readmemh("hw/sbox/sbox_table.hex", rom);   // sixteen bytes per line.
    end

    // registered read, one cycle latency.
    always_ff @(posedge clk)
    begin
        data <= rom[addr];
    end

endmodule

`default_nettype wire

// ==== hw/round/aes_round.sv ====
// state_out is undefined until the first load and is held from DONE until the next load.
`timescale 1ns/1ps
`default_nettype none

module aes_round
    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;
(
    input  logic       clk,         // core clock.
    input  round_cmd_t cmd,         // sequencer command.
    input  aes_block_t plaintext,   // taken on load.
    input  aes_block_t round_key,   // key of the round being finished.
    output aes_block_t state_out    // cipher state.
);

    aes_block_t state_q;      // cipher state.
    aes_block_t sub_blk;      // SubBytes result, from the ROMs.
    aes_block_t shift_blk;    // after ShiftRows.
    aes_block_t mix_blk;      // after MixColumns or its bypass.

    // ********************************************************************
    // round functions
    // ********************************************************************

    // state byte s[r][c] sits at index r + 4c, row r rotates left by r.
    function automatic aes_block_t shift_rows(input aes_block_t b);
        aes_block_t r;
        int         col;
        int         row;
        for (col = 0; col < 4; col++)
        begin
            for (row = 0; row < 4; row++)
            begin
                r[127-8*(row+4*col) -: 8] = b[127-8*(row+4*((col+row)%4)) -: 8];
            end
        end
        return r;
    endfunction

    // one column times the fixed {02 03 01 01} circulant.
    function automatic aes_word_t mix_column(input aes_word_t w);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    function automatic aes_block_t mix_columns(input aes_block_t b);
        aes_block_t r;
        int         col;
        for (col = 0; col < 4; col++)
        begin
            r[127-32*col -: 32] = mix_column(b[127-32*col -: 32]);   // column col.
        end
        return r;
    endfunction

    // ********************************************************************
    // SubBytes, sixteen ROMs
    // ********************************************************************
    for (genvar k = 0; k < 16; k++)
    begin : g_sbox
        sbox_rom u_sbox (
            .clk  (clk),
            .addr (state_q[127-8*k -: 8]),   // state byte k.
            .data (sub_blk[127-8*k -: 8])
        );
    end

    assign shift_blk = shift_rows(sub_blk);
    assign mix_blk   = cmd.last ? shift_blk : mix_columns(shift_blk);   // round 14 skips it.

    // state update, the ROM outputs were read in the SUB cycle before each step.
    always_ff @(posedge clk)
    begin
        if (cmd.load)
        begin
            state_q <= plaintext ^ round_key;   // initial AddRoundKey.
        end
        else if (cmd.step)
        begin
            state_q <= mix_blk ^ round_key;     // AddRoundKey closes the round.
        end
    end

    assign state_out = state_q;

endmodule

`default_nettype wire

// ==== hw/aes_key_expand.sv ====
// encrypt key schedule only; the key is re-expanded on every load, and round_key is valid once load is seen.
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand
    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;
(
    input  logic       clk,         // core clock.
    input  logic       rst_n,       // synchronous, active low.
    input  round_cmd_t cmd,         // sequencer command.
    input  aes_key_t   key,         // cipher key, held during the run.
    output aes_block_t round_key    // key of the current round.
);

    aes_word_t win_q [8];   // last eight schedule words, oldest in slot 0.
    aes_byte_t rcon_q;      // round constant.
    logic      phase_q;     // 0 for the RotWord step, 1 for SubWord only.
    aes_word_t sub_w;       // SubWord of the newest word.
    aes_word_t temp_w;      // word mixed into the oldest one.
    aes_word_t new_w [4];   // next four schedule words.

    // ********************************************************************
    // SubWord, four ROMs on the newest window word
    // ********************************************************************
    for (genvar k = 0; k < 4; k++)
    begin : g_sbox
        sbox_rom u_sbox (
            .clk  (clk),
            .addr (win_q[7][31-8*k -: 8]),
            .data (sub_w[31-8*k -: 8])
        );
    end

    // RotWord after SubWord equals SubWord after RotWord, bytes move alone.
    assign temp_w = phase_q ? sub_w
                            : ({sub_w[23:0], sub_w[31:24]} ^ {rcon_q, 24'h000000});

    // chained XORs, FIPS-197 with Nk = 8.
    always_comb
    begin
        new_w[0] = win_q[0] ^ temp_w;
        new_w[1] = win_q[1] ^ new_w[0];
        new_w[2] = win_q[2] ^ new_w[1];
        new_w[3] = win_q[3] ^ new_w[2];
    end

    // ********************************************************************
    // window and constant update
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (cmd.load)
        begin
            for (int i = 0; i < 8; i++)
            begin
                win_q[i] <= key[255-32*i -: 32];   // whole key, word 0 first.
            end
        end
        else if (cmd.step)
        begin
            for (int i = 0; i < 4; i++)
            begin
                win_q[i]   <= win_q[i+4];   // slide by four words.
                win_q[i+4] <= new_w[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rcon_q  <= RCON_INIT;
            phase_q <= 1'b0;
        end
        else if (cmd.load)
        begin
            rcon_q  <= RCON_INIT;   // restart per request.
            phase_q <= 1'b0;
        end
        else if (cmd.step)
        begin
            phase_q <= ~phase_q;    // step kinds alternate.
            if (!phase_q)
            begin
                rcon_q <= xtime(rcon_q);   // used, so double it.
            end
        end
    end

    // round key 0 comes straight from the key, later ones from the newer half.
    assign round_key = cmd.load ? key[255:128] : {win_q[4], win_q[5], win_q[6], win_q[7]};

endmodule

`default_nettype wire

// ==== hw/aes_ctrl.sv ====
// one encryption per req; a new req is taken only from IDLE and ack rises 30 edges after req is sampled.
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl
    import aes_ctrl_pkg::*;
(
    input  logic       clk,     // core clock.
    input  logic       rst_n,   // synchronous, active low.
    input  logic       req,     // host request.
    output logic       ack,     // host acknowledge.
    output round_cmd_t cmd      // command to the datapaths.
);

    aes_ctrl_state_e state_q;   // current state.
    aes_ctrl_state_e state_d;   // next state.
    round_cnt_t      round_q;   // round in progress, 1 to NUM_ROUNDS.
    round_cnt_t      round_d;
    logic            final_round;

    assign final_round = (round_q == round_cnt_t'(NUM_ROUNDS));

    // ********************************************************************
    // round sequencer
    // ********************************************************************
    always_comb
    begin
        state_d = state_q;   // hold by default.
        round_d = round_q;
        case (state_q)
            IDLE:
            begin
                if (req)
                begin
                    state_d = LOAD;   // req seen from idle only.
                end
            end
            LOAD:
            begin
                state_d = SUB;
                round_d = round_cnt_t'(1);   // first round follows.
            end
            SUB:
            begin
                state_d = MIX;   // ROM outputs are registered now.
            end
            MIX:
            begin
                if (final_round)
                begin
                    state_d = DONE;
                end
                else
                begin
                    state_d = SUB;
                    round_d = round_q + round_cnt_t'(1);
                end
            end
            DONE:
            begin
                if (!req)
                begin
                    state_d = IDLE;   // host has seen ack.
                end
            end
            default:
            begin
                state_d = IDLE;   // unused encodings.
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            round_q <= '0;
            ack     <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            round_q <= round_d;
            ack     <= (state_q == DONE) && req;   // falls with the edge that sees req low.
        end
    end

    // ********************************************************************
    // command decode
    // ********************************************************************
    always_comb
    begin
        cmd      = '0;   // all low outside a run.
        cmd.load = (state_q == LOAD);
        cmd.sub  = (state_q == SUB);
        cmd.step = (state_q == MIX);
        cmd.last = ((state_q == SUB) || (state_q == MIX)) && final_round;
    end

endmodule

`default_nettype wire

// ==== hw/aes256_enc.sv ====
// encrypt only; req_data must stay unchanged while req is high and ct is valid from ack until next req.
`timescale 1ns/1ps
`default_nettype none

module aes256_enc
    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;
(
    input  logic       clk,        // core clock.
    input  logic       rst_n,      // synchronous, active low.
    input  logic       req,        // four-phase request from the host.
    input  enc_req_t   req_data,   // key and plaintext, held while req is high.
    output logic       ack,        // ciphertext ready.
    output aes_block_t ct          // ciphertext, held until the next load.
);

    // ********************************************************************
    // internal wiring
    // ********************************************************************
    round_cmd_t cmd;          // sequencer command, shared by both datapaths.
    aes_block_t round_key;    // key of the round being finished.
    aes_block_t state_out;    // cipher state register.

    // sequencer and host handshake.
    aes_ctrl u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .ack   (ack),
        .cmd   (cmd)
    );

    // on the fly key schedule.
    aes_key_expand u_key_expand (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .key       (req_data.key),
        .round_key (round_key)
    );

    // ********************************************************************
    // round datapath
    // ********************************************************************
    aes_round u_round (
        .clk       (clk),
        .cmd       (cmd),
        .plaintext (req_data.plaintext),
        .round_key (round_key),
        .state_out (state_out)
    );

    assign ct = state_out;   // the state register is the ciphertext after round 14.

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// free-running 40 ns clock from time zero; rst_n is released 2 ns after the third rising edge.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic clk,     // testbench clock.
    output logic rst_n    // synchronous reset, active low.
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;   // half of the 40 ns period.
        end
    end

    // three clocks of reset, released off the edge like every other input.
    initial
    begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/aes256_enc_props.sv ====
// bound into every aes_ctrl instance; reads the FSM state by name and expects a host that holds req until ack.
`timescale 1ns/1ps
`default_nettype none

module aes256_enc_props
    import aes_ctrl_pkg::*;
(
    input logic            clk,
    input logic            rst_n,
    input logic            req,
    input logic            ack,
    input round_cmd_t      cmd,
    input aes_ctrl_state_e state_q
);

    // ********************************************************************
    // handshake
    // ********************************************************************
    // IDLE took req 31 samples before ack rises: LOAD, the rounds, DONE entry.
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past((state_q == IDLE) && req, 2 * NUM_ROUNDS + 3))
        else $error("ack rose without a request taken from IDLE");   // four-phase order.

    // ********************************************************************
    // command struct
    // ********************************************************************
    a_cmd_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || !req) |-> (cmd == '0))
        else $error("command active outside a run");

    // last only on the SUB and MIX cycles of round 14, counted from load.
    a_last_final: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.last |-> ((cmd.sub && $past(cmd.load, 2 * NUM_ROUNDS - 1))
                   || (cmd.step && $past(cmd.load, 2 * NUM_ROUNDS))))
        else $error("last flag set outside the final round");

endmodule

bind aes_ctrl aes256_enc_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .cmd     (cmd),
    .state_q (state_q)
);

`default_nettype wire

// ==== tb/tb_aes256_enc.sv ====
// run from the project root; vectors come from tb/aes256_golden.txt, random gaps use seed 5.
`timescale 1ns/1ps
`default_nettype none

module tb_aes256_enc
    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       req;
    enc_req_t   req_data;
    logic       ack;
    aes_block_t ct;

    int check_cnt;     // comparisons made.
    int err_cnt;       // failed comparisons and other errors.
    int timeout_cnt;   // waits that ran out.
    int vec_cnt;       // golden vectors run.
    bit abort;         // stop after a hung handshake.

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    aes256_enc dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .ct       (ct)
    );

    // ********************************************************************
    // helpers
    // ********************************************************************
    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // returns 1 ns after the edge, outputs are settled there.
    task automatic wait_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_ack(input logic level, output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 100)   // 100 cycle timeout.
        begin
            wait_cycle();
            cycles++;
            seen = (ack === level);
        end
    endtask

    // one full four-phase transfer with timing and hold checks.
    task automatic run_vector(input aes_key_t key, input aes_block_t pt,
                              input aes_block_t exp_ct, output bit failed);
        int unsigned gap;
        int unsigned hold;
        int          cycles;
        bit          seen;
        failed = 1'b0;
        gap    = $urandom_range(4, 1);
        repeat (gap)
        begin
            wait_cycle();
            check_value("ack", 128'(ack), 128'(0));   // idle, req low.
        end
        #1;   // inputs change 2 ns after the edge.
        req_data.key       = key;
        req_data.plaintext = pt;
        req                = 1'b1;
        wait_for_ack(1'b1, cycles, seen);
        if (!seen)
        begin
            $display("timeout: ack did not rise within 100 cycles of req");
            timeout_cnt++;
            failed = 1'b1;
        end
        else
        begin
            // first counted edge samples req, ack follows LOAD, the rounds and DONE.
            check_value("ack_latency", 128'(cycles - 1), 128'(2 * NUM_ROUNDS + 2));
            check_value("ct", ct, exp_ct);
            hold = $urandom_range(5, 0);   // slow host.
            repeat (hold)
            begin
                wait_cycle();
                check_value("ack", 128'(ack), 128'(1));
                check_value("ct", ct, exp_ct);
            end
            #1;
            req      = 1'b0;
            req_data = enc_req_t'(~req_data);   // ct must not follow the inputs.
            wait_for_ack(1'b0, cycles, seen);
            if (!seen)
            begin
                $display("timeout: ack did not fall within 100 cycles of req dropping");
                timeout_cnt++;
                failed = 1'b1;
            end
            else
            begin
                check_value("ack_fall_delay", 128'(cycles), 128'(1));
                check_value("ct", ct, exp_ct);   // held after ack falls.
            end
        end
    endtask

    // ********************************************************************
    // main sequence
    // ********************************************************************
    initial
    begin
        int         fd;
        int         n;
        int         wait_cnt;
        string      line;
        aes_key_t   v_key;
        aes_block_t v_pt;
        aes_block_t v_ct;
        req         = 1'b0;
        req_data    = '0;
        check_cnt   = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        vec_cnt     = 0;
        abort       = 1'b0;
        void'($urandom(5));
        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < 10)
        begin
            wait_cycle();
            wait_cnt++;
        end
        if (rst_n !== 1'b1)
        begin
            $display("timeout: reset was never released");
            timeout_cnt++;
            abort = 1'b1;
        end
        else
        begin
            repeat (4)
            begin
                wait_cycle();
                check_value("ack", 128'(ack), 128'(0));   // quiet after reset.
            end
        end
        fd = $fopen("tb/aes256_golden.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tb/aes256_golden.txt");
            err_cnt++;
        end
        else
        begin
            while (!abort && $feof(fd) == 0)
            begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%h %h %h", v_key, v_pt, v_ct);
                    if (n != 3)
                    begin
                        $display("malformed line in golden file: %s", line);
                        err_cnt++;
                    end
                    else
                    begin
                        vec_cnt++;
                        run_vector(v_key, v_pt, v_ct, abort);
                    end
                end
            end
            $fclose(fd);
        end
        if (vec_cnt == 0)
        begin
            $display("no golden vectors were run");
            err_cnt++;
        end
        $display("checks=%0d errors=%0d timeouts=%0d vectors=%0d",
                 check_cnt, err_cnt, timeout_cnt, vec_cnt);
        if (err_cnt == 0 && timeout_cnt == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/aes256_golden.txt ====
# columns: key (64 hex digits) plaintext (32) expected ciphertext (32), byte 0 first
# lines starting with # are skipped
000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
0000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 dc95c078a2408989ad48a21492842087
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 00000000000000000000000000000000 4bf85f1b5d54adbc307b0a048389adcb
8000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 e35a6dcb19b201a01ebcfa8aa22b5759
0000000000000000000000000000000000000000000000000000000000000000 80000000000000000000000000000000 ddc6bf790c15760d8d9aeb6f9a75fd4e
0000000000000000000000000000000000000000000000000000000000000000 014730f80ac625fe84f026c60bfd547d 5c9d844ed46f9885085e5d6a4f94c7d7
c47b0294dbbbee0fec4757f22ffeee3587ca4730c3d33b691df38bab076bc558 00000000000000000000000000000000 46f2fb342d6f0ab477476fc501242c5f
603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8

// ==== hw/sbox/sbox_table.hex ====
63 7c 77 7b f2 6b 6f c5 30 01 67 2b fe d7 ab 76
ca 82 c9 7d fa 59 47 f0 ad d4 a2 af 9c a4 72 c0
b7 fd 93 26 36 3f f7 cc 34 a5 e5 f1 71 d8 31 15
04 c7 23 c3 18 96 05 9a 07 12 80 e2 eb 27 b2 75
09 83 2c 1a 1b 6e 5a a0 52 3b d6 b3 29 e3 2f 84
53 d1 00 ed 20 fc b1 5b 6a cb be 39 4a 4c 58 cf
d0 ef aa fb 43 4d 33 85 45 f9 02 7f 50 3c 9f a8
51 a3 40 8f 92 9d 38 f5 bc b6 da 21 10 ff f3 d2
cd 0c 13 ec 5f 97 44 17 c4 a7 7e 3d 64 5d 19 73
60 81 4f dc 22 2a 90 88 46 ee b8 14 de 5e 0b db
e0 32 3a 0a 49 06 24 5c c2 d3 ac 62 91 95 e4 79
e7 c8 37 6d 8d d5 4e a9 6c 56 f4 ea 65 7a ae 08
ba 78 25 2e 1c a6 b4 c6 e8 dd 74 1f 4b bd 8b 8a
70 3e b5 66 48 03 f6 0e 61 35 57 b9 86 c1 1d 9e
e1 f8 98 11 69 d9 8e 94 9b 1e 87 e9 ce 55 28 df
8c a1 89 0d bf e6 42 68 41 99 2d 0f b0 54 bb 16

// ==== aes256_enc.f ====
common/aes_types_pkg.sv
common/aes_ctrl_pkg.sv
hw/sbox/sbox_rom.sv
hw/round/aes_round.sv
hw/aes_key_expand.sv
hw/aes_ctrl.sv
hw/aes256_enc.sv
tb/tb_clock_gen.sv
tb/aes256_enc_props.sv
tb/tb_aes256_enc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the AES-256 testbench with Verilator from the project root.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=Vtb_aes256_enc

verilator --binary --timing --assert \
    --top-module tb_aes256_enc \
    -f aes256_enc.f \
    -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "testbench reported failure, see $LOG"
    exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi

echo "run finished cleanly"
exit 0
